/* tb.f */
+incdir+verif
common/wb_pkg.sv
common/fir_pkg.sv
exmem/exmem_ram.sv
fir/fir_engine.sv
design/access_timer.sv
design/bus_ctrl.sv
design/wb_fir_top.sv
verif/tb_top.sv

/* Makefile */
# Verilator build and run of the Wishbone FIR slave testbench

VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q ">>> PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verif/tb_tasks.svh */
// Wishbone bus cycle tasks, memory byte merge and reference FIR output model
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// one classic cycle, lat counts cycles from the capture edge to ack
task automatic bus_cycle(input logic we, input logic [3:0] sel, input logic [31:0] adr,
                         input logic [31:0] wdata, output logic [31:0] rdata,
                         output int lat);
    @(posedge clk);
    wbs_cyc_i <= 1'b1;
    wbs_stb_i <= 1'b1;
    wbs_we_i  <= we;
    wbs_sel_i <= sel;
    wbs_adr_i <= adr;
    wbs_dat_i <= wdata;
    // slave samples the request here
    @(posedge clk);
    lat = 0;
    @(negedge clk);
    while (!wbs_ack_o) begin
        @(negedge clk);
        lat++;
    end
    rdata = wbs_dat_o;
    @(posedge clk);
    wbs_cyc_i <= 1'b0;
    wbs_stb_i <= 1'b0;
    wbs_we_i  <= 1'b0;
    @(negedge clk);
    check_cond(!wbs_ack_o, "ack stayed high for more than one cycle");
endtask

task automatic write_word(input logic [31:0] adr, input logic [31:0] data,
                          input logic [3:0] sel, output int lat);
    logic [31:0] unused;
    bus_cycle(1'b1, sel, adr, data, unused, lat);
endtask

task automatic read_word(input logic [31:0] adr, output logic [31:0] data, output int lat);
    bus_cycle(1'b0, 4'hF, adr, 32'h0, data, lat);
endtask

// memory image update for a byte-enabled write
function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
                                            input logic [3:0] sel);
    logic [31:0] res;
    res = old;
    for (int b = 0; b < 4; b++) begin
        if (sel[b]) begin
            res[8*b +: 8] = data[8*b +: 8];
        end
    end
    return res;
endfunction

// y[n] = sum h[k] * x[n-k], newest sample at the back, 32-bit wrap
function automatic logic [31:0] fir_output(input logic [31:0] h [TAP_NUM],
                                           input logic [31:0] xs [$]);
    logic [31:0] acc;
    int          n;
    acc = '0;
    n   = xs.size();
    for (int k = 0; k < TAP_NUM && k < n; k++) begin
        acc = acc + h[k] * xs[n-1-k];
    end
    return acc;
endfunction

`endif

/* verif/tb_top.sv */
// testbench: clock, reset, DUT, LCG, tests against a model, watchdog and summary
module tb_top;
    import wb_pkg::*;
    import fir_pkg::*;

    localparam int CLK_PERIOD   = 100;
    localparam int MEM_WORDS    = 16;
    localparam int LAT_PAIRS    = 4;
    localparam int UNMAPPED_NUM = 6;
    localparam int STREAM_LEN   = 24;
    localparam int DONE_LEN     = 6;
    localparam int POLL_MAX     = 8;
    // worst bus cycle in clocks, drive and release included
    localparam int CYCLE_BOUND  = 40;
    localparam int ACCESS_COUNT = 3 * MEM_WORDS + 2 * LAT_PAIRS + UNMAPPED_NUM
                                + TAP_NUM + 2 + 2 * STREAM_LEN
                                + 3 * DONE_LEN + 6
                                + 8 + POLL_MAX;

    logic        clk;
    logic        rst;
    logic        wbs_cyc_i;
    logic        wbs_stb_i;
    logic        wbs_we_i;
    logic [3:0]  wbs_sel_i;
    logic [31:0] wbs_adr_i;
    logic [31:0] wbs_dat_i;
    logic        wbs_ack_o;
    logic [31:0] wbs_dat_o;

    logic [31:0] lcg_state;
    int          checks;
    int          errors;
    int          checks_mark;
    int          errors_mark;
    int          tests;

    // models
    logic [31:0] mem_model [MEM_DEPTH];
    logic [31:0] taps [TAP_NUM];
    logic [31:0] xs [$];

    wb_fir_top u_dut (
        .clk       (clk),
        .rst       (rst),
        .wbs_cyc_i (wbs_cyc_i),
        .wbs_stb_i (wbs_stb_i),
        .wbs_we_i  (wbs_we_i),
        .wbs_sel_i (wbs_sel_i),
        .wbs_adr_i (wbs_adr_i),
        .wbs_dat_i (wbs_dat_i),
        .wbs_ack_o (wbs_ack_o),
        .wbs_dat_o (wbs_dat_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ------------------------------------------------------------
    // checks and helpers
    // ------------------------------------------------------------
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("ERROR %s: got 0x%08h, expected 0x%08h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_cond(input logic ok, input string what);
        checks++;
        assert (ok) else begin
            $display("%s", what);
            errors++;
        end
    endtask

    task automatic check_latency(input string what, input int lat, input int exp);
        check_cond(lat == exp, $sformatf("%s acked %0d cycles after capture instead of %0d",
                                         what, lat, exp));
    endtask

    task automatic report_test(input string name);
        $display("%-15s %0d checks, %0d errors", name, checks - checks_mark,
                 errors - errors_mark);
        checks_mark = checks;
        errors_mark = errors;
        tests++;
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [31:0] mem_addr(input logic [MEM_AW-1:0] idx);
        return MEM_BASE + (32'(idx) << 2);
    endfunction

    `include "tb_tasks.svh"

    // one x write followed by its y read, checked against the model
    task automatic push_and_pop(input logic [31:0] x);
        logic [31:0] y;
        int          lat;
        write_word(FIR_BASE + REG_X, x, 4'hF, lat);
        xs.push_back(x);
        read_word(FIR_BASE + REG_Y, y, lat);
        check_value("wbs_dat_o", y, fir_output(taps, xs));
    endtask

    // ------------------------------------------------------------
    // tests
    // ------------------------------------------------------------
    task automatic mem_readback();
        logic [MEM_AW-1:0] idx [MEM_WORDS];
        logic [MEM_AW-1:0] base;
        logic [31:0]       data;
        logic [31:0]       rd;
        logic [3:0]        sel;
        int                pick;
        int                lat;
        base = MEM_AW'(lcg_next() >> 12);
        // full words first so every byte is known
        for (int i = 0; i < MEM_WORDS; i++) begin
            idx[i] = base + MEM_AW'(i * 67);
            data   = lcg_next();
            write_word(mem_addr(idx[i]), data, 4'hF, lat);
            mem_model[idx[i]] = data;
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            pick = int'((lcg_next() >> 16) % MEM_WORDS);
            sel  = 4'(lcg_next() >> 24);
            data = lcg_next();
            write_word(mem_addr(idx[pick]), data, sel, lat);
            mem_model[idx[pick]] = merge_bytes(mem_model[idx[pick]], data, sel);
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            read_word(mem_addr(idx[i]), rd, lat);
            check_value("wbs_dat_o", rd, mem_model[idx[i]]);
        end
        report_test("mem_readback");
    endtask

    task automatic mem_latency();
        logic [MEM_AW-1:0] idx;
        logic [31:0]       data;
        logic [31:0]       rd;
        int                lat;
        for (int i = 0; i < LAT_PAIRS; i++) begin
            idx  = MEM_AW'(lcg_next() >> 8);
            data = lcg_next();
            write_word(mem_addr(idx), data, 4'hF, lat);
            check_latency("memory write", lat, MEM_DELAY + 1);
            mem_model[idx] = data;
            read_word(mem_addr(idx), rd, lat);
            check_latency("memory read", lat, MEM_DELAY + 1);
            check_value("wbs_dat_o", rd, mem_model[idx]);
        end
        report_test("mem_latency");
    endtask

    task automatic unmapped_reads();
        logic [31:0] adrs [UNMAPPED_NUM];
        logic [31:0] rd;
        int          lat;
        // outside both windows, or holes inside the filter window
        adrs = '{32'h3400_0000 | (lcg_next() & 32'h00FF_FFFC), 32'h3000_0014,
                 32'h3000_0040, 32'h3000_00AC, 32'h3000_0100,
                 32'h0000_1000 | (lcg_next() & 32'h0000_0FFC)};
        for (int i = 0; i < UNMAPPED_NUM; i++) begin
            read_word(adrs[i], rd, lat);
            check_value("wbs_dat_o", rd, 32'h0);
            check_latency("unmapped read", lat, 1);
        end
        report_test("unmapped_reads");
    endtask

    task automatic filter_stream();
        int lat;
        for (int k = 0; k < TAP_NUM; k++) begin
            taps[k] = lcg_next();
            write_word(FIR_BASE + REG_TAP0 + 4 * k, taps[k], 4'hF, lat);
            check_latency("tap write", lat, 3);
        end
        write_word(FIR_BASE + REG_LEN, STREAM_LEN, 4'hF, lat);
        write_word(FIR_BASE + REG_CTRL, 32'h1, 4'hF, lat);
        xs.delete();
        for (int i = 0; i < STREAM_LEN; i++) begin
            push_and_pop(lcg_next());
        end
        report_test("filter_stream");
    endtask

    task automatic done_status();
        logic [31:0] st;
        logic [31:0] x;
        logic [31:0] y;
        int          lat;
        write_word(FIR_BASE + REG_LEN, DONE_LEN, 4'hF, lat);
        write_word(FIR_BASE + REG_CTRL, 32'h1, 4'hF, lat);
        xs.delete();
        for (int i = 0; i < DONE_LEN; i++) begin
            push_and_pop(lcg_next());
            read_word(FIR_BASE + REG_CTRL, st, lat);
            check_value("wbs_dat_o[0]", {31'd0, st[0]}, (i == DONE_LEN - 1) ? 32'h1 : 32'h0);
        end
        // restart clears done and the history
        write_word(FIR_BASE + REG_CTRL, 32'h1, 4'hF, lat);
        xs.delete();
        read_word(FIR_BASE + REG_CTRL, st, lat);
        check_value("wbs_dat_o[0]", {31'd0, st[0]}, 32'h0);
        x = lcg_next();
        write_word(FIR_BASE + REG_X, x, 4'hF, lat);
        xs.push_back(x);
        read_word(FIR_BASE + REG_Y, y, lat);
        check_value("wbs_dat_o", y, taps[0] * x);
        report_test("done_status");
    endtask

    task automatic back_pressure();
        logic [31:0] st;
        logic [31:0] x;
        logic [31:0] y;
        int          lat;
        int          polls;
        write_word(FIR_BASE + REG_CTRL, 32'h1, 4'hF, lat);
        xs.delete();
        // y read lands while the MAC is still running
        x = lcg_next();
        write_word(FIR_BASE + REG_X, x, 4'hF, lat);
        xs.push_back(x);
        read_word(FIR_BASE + REG_Y, y, lat);
        check_cond(lat > 3, $sformatf("y read was not held off, acked after %0d cycles", lat));
        check_value("wbs_dat_o", y, fir_output(taps, xs));
        // result pending, so no further x is taken
        x = lcg_next();
        write_word(FIR_BASE + REG_X, x, 4'hF, lat);
        xs.push_back(x);
        st    = '0;
        polls = 0;
        while (!st[2] && polls < POLL_MAX) begin
            read_word(FIR_BASE + REG_CTRL, st, lat);
            polls++;
        end
        check_cond(st[2], "y_valid never came up while polling the status word");
        check_value("wbs_dat_o[1]", {31'd0, st[1]}, 32'h0);
        read_word(FIR_BASE + REG_Y, y, lat);
        check_value("wbs_dat_o", y, fir_output(taps, xs));
        read_word(FIR_BASE + REG_CTRL, st, lat);
        check_value("wbs_dat_o[2:1]", {30'd0, st[2:1]}, 32'h1);
        push_and_pop(lcg_next());
        report_test("back_pressure");
    endtask

    // ------------------------------------------------------------
    // main sequence and watchdog
    // ------------------------------------------------------------
    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        wbs_cyc_i   = 1'b0;
        wbs_stb_i   = 1'b0;
        wbs_we_i    = 1'b0;
        wbs_sel_i   = 4'h0;
        wbs_adr_i   = 32'h0;
        wbs_dat_i   = 32'h0;
        lcg_state   = 32'h2202_8240;
        checks      = 0;
        errors      = 0;
        checks_mark = 0;
        errors_mark = 0;
        tests       = 0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        mem_readback();
        mem_latency();
        unmapped_reads();
        filter_stream();
        done_status();
        back_pressure();
        $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        #((CYCLE_BOUND * ACCESS_COUNT + 2) * CLK_PERIOD);
        $display("watchdog expired, the tests did not finish within %0d bus cycles",
                 ACCESS_COUNT);
        $display(">>> FAIL");
        $finish;
    end

endmodule

/* design/wb_fir_top.sv */
// top level: bus controller, memory timer, memory array and filter engine
module wb_fir_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          wbs_cyc_i,
    input  logic                          wbs_stb_i,
    input  logic                          wbs_we_i,
    input  logic [wb_pkg::WB_SEL_W-1:0]   wbs_sel_i,
    input  logic [wb_pkg::WB_ADDR_W-1:0]  wbs_adr_i,
    input  logic [wb_pkg::WB_DATA_W-1:0]  wbs_dat_i,
    output logic                          wbs_ack_o,
    output logic [wb_pkg::WB_DATA_W-1:0]  wbs_dat_o
);
    import wb_pkg::*;
    import fir_pkg::*;

    // memory side
    logic                 mem_start;
    logic                 mem_done;
    mem_req_t             mem_req;
    logic [WB_DATA_W-1:0] mem_rdata;

    // filter side
    logic                 fir_req;
    logic                 fir_ack;
    fir_cmd_t             fir_cmd;
    logic [31:0]          fir_rdata;

    bus_ctrl u_bus_ctrl (
        .clk         (clk),
        .rst         (rst),
        .wbs_cyc_i   (wbs_cyc_i),
        .wbs_stb_i   (wbs_stb_i),
        .wbs_we_i    (wbs_we_i),
        .wbs_sel_i   (wbs_sel_i),
        .wbs_adr_i   (wbs_adr_i),
        .wbs_dat_i   (wbs_dat_i),
        .wbs_ack_o   (wbs_ack_o),
        .wbs_dat_o   (wbs_dat_o),
        .mem_start_o (mem_start),
        .mem_req_o   (mem_req),
        .mem_done_i  (mem_done),
        .mem_rdata_i (mem_rdata),
        .fir_req_o   (fir_req),
        .fir_cmd_o   (fir_cmd),
        .fir_ack_i   (fir_ack),
        .fir_rdata_i (fir_rdata)
    );

    access_timer u_access_timer (
        .clk     (clk),
        .rst     (rst),
        .start_i (mem_start),
        .done_o  (mem_done)
    );

    exmem_ram u_exmem_ram (
        .clk     (clk),
        .start_i (mem_start),
        .req_i   (mem_req),
        .rdata_o (mem_rdata)
    );

    fir_engine u_fir_engine (
        .clk     (clk),
        .rst     (rst),
        .req_i   (fir_req),
        .cmd_i   (fir_cmd),
        .ack_o   (fir_ack),
        .rdata_o (fir_rdata)
    );

endmodule

/* design/bus_ctrl.sv */
// Wishbone slave FSM: request capture, target decode, memory and filter steering, ack
module bus_ctrl (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          wbs_cyc_i,
    input  logic                          wbs_stb_i,
    input  logic                          wbs_we_i,
    input  logic [wb_pkg::WB_SEL_W-1:0]   wbs_sel_i,
    input  logic [wb_pkg::WB_ADDR_W-1:0]  wbs_adr_i,
    input  logic [wb_pkg::WB_DATA_W-1:0]  wbs_dat_i,
    output logic                          wbs_ack_o,
    output logic [wb_pkg::WB_DATA_W-1:0]  wbs_dat_o,
    output logic                          mem_start_o,
    output wb_pkg::mem_req_t              mem_req_o,
    input  logic                          mem_done_i,
    input  logic [wb_pkg::WB_DATA_W-1:0]  mem_rdata_i,
    output logic                          fir_req_o,
    output fir_pkg::fir_cmd_t             fir_cmd_o,
    input  logic                          fir_ack_i,
    input  logic [31:0]                   fir_rdata_i
);
    import wb_pkg::*;
    import fir_pkg::*;

    typedef enum logic [2:0] {IDLE, MEM_WAIT, FIR_REQ, FIR_REL, ACK, HOLD} state_e;
    typedef enum logic [1:0] {TGT_NONE, TGT_MEM, TGT_FIR} tgt_e;

    typedef struct packed {
        logic      hit;
        fir_kind_e kind;
    } fir_dec_t;

    state_e                 state;
    wb_req_t                req_q;
    tgt_e                   cap_tgt;
    fir_dec_t               dec_q;
    logic [REG_OFF_W-1:0]   tap_off;
    logic [WB_DATA_W-1:0]   byte_mask;
    logic                   capture;

    // register decode inside the filter window, direction matters
    function automatic fir_dec_t fir_decode(input logic we, input logic [REG_OFF_W-1:0] off);
        fir_dec_t d;
        d.hit  = 1'b1;
        d.kind = we ? CMD_CTRL_WR : CMD_STAT_RD;
        if (off == REG_LEN && we) begin
            d.kind = CMD_LEN_WR;
        end else if (off == REG_X && we) begin
            d.kind = CMD_X_PUSH;
        end else if (off == REG_Y && !we) begin
            d.kind = CMD_Y_POP;
        end else if (we && off >= REG_TAP0 && off <= REG_TAP0 + 4 * (TAP_NUM - 1)
                     && off[1:0] == 2'b00) begin
            d.kind = CMD_TAP_WR;
        end else if (off != REG_CTRL) begin
            d.hit = 1'b0;
        end
        return d;
    endfunction

    function automatic tgt_e target_of(input logic we, input logic [WB_ADDR_W-1:0] adr);
        fir_dec_t d;
        d = fir_decode(we, adr[REG_OFF_W-1:0]);
        if (adr[WB_ADDR_W-1:MEM_AW+2] == MEM_BASE[WB_ADDR_W-1:MEM_AW+2]) begin
            return TGT_MEM;
        end
        if (adr[WB_ADDR_W-1:REG_OFF_W] == FIR_BASE[WB_ADDR_W-1:REG_OFF_W] && d.hit) begin
            return TGT_FIR;
        end
        return TGT_NONE;
    endfunction

    assign capture = (state == IDLE) && wbs_cyc_i && wbs_stb_i;
    assign cap_tgt = target_of(wbs_we_i, wbs_adr_i);

    always_ff @(posedge clk) begin
        if (capture) begin
            req_q <= '{we: wbs_we_i, sel: wbs_sel_i, adr: wbs_adr_i, dat: wbs_dat_i};
        end
    end

    // ------------------------------------------------------------
    // outgoing requests, built from the captured request
    // ------------------------------------------------------------
    always_comb begin
        for (int b = 0; b < WB_SEL_W; b++) begin
            byte_mask[8*b +: 8] = {8{req_q.sel[b]}};
        end
    end

    assign mem_req_o.we    = req_q.sel & {WB_SEL_W{req_q.we}};
    assign mem_req_o.addr  = req_q.adr[MEM_AW+1:2];
    assign mem_req_o.wdata = req_q.dat & byte_mask;

    assign dec_q   = fir_decode(req_q.we, req_q.adr[REG_OFF_W-1:0]);
    assign tap_off = req_q.adr[REG_OFF_W-1:0] - REG_TAP0;

    assign fir_cmd_o.kind = dec_q.kind;
    assign fir_cmd_o.tap  = tap_off[TAP_IW+1:2];
    assign fir_cmd_o.data = req_q.dat;

    // ------------------------------------------------------------
    // main FSM
    // ------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= IDLE;
            wbs_ack_o   <= 1'b0;
            wbs_dat_o   <= '0;
            mem_start_o <= 1'b0;
            fir_req_o   <= 1'b0;
        end else begin
            wbs_ack_o   <= 1'b0;
            wbs_dat_o   <= '0;
            mem_start_o <= 1'b0;
            case (state)
                IDLE: begin
                    if (capture) begin
                        case (cap_tgt)
                            TGT_MEM: begin
                                mem_start_o <= 1'b1;
                                state       <= MEM_WAIT;
                            end
                            TGT_FIR: begin
                                fir_req_o <= 1'b1;
                                state     <= FIR_REQ;
                            end
                            default: state <= ACK;
                        endcase
                    end
                end
                MEM_WAIT: begin
                    if (mem_done_i) begin
                        wbs_ack_o <= 1'b1;
                        wbs_dat_o <= req_q.we ? '0 : mem_rdata_i;
                        state     <= HOLD;
                    end
                end
                // engine may stretch here for back-pressure
                FIR_REQ: begin
                    if (fir_ack_i) begin
                        fir_req_o <= 1'b0;
                        state     <= FIR_REL;
                    end
                end
                FIR_REL: begin
                    wbs_ack_o <= 1'b1;
                    wbs_dat_o <= req_q.we ? '0 : fir_rdata_i;
                    state     <= HOLD;
                end
                ACK: begin
                    wbs_ack_o <= 1'b1;
                    state     <= HOLD;
                end
                // stb ignored here, also lets the filter ack drop
                HOLD: begin
                    if (!fir_ack_i) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    a_ack_single: assert property (@(posedge clk) disable iff (rst)
        wbs_ack_o |=> !wbs_ack_o);

    a_req_held: assert property (@(posedge clk) disable iff (rst)
        fir_req_o && !fir_ack_i |=> fir_req_o);

endmodule

/* design/access_timer.sv */
// memory access delay counter
module access_timer (
    input  logic clk,
    input  logic rst,
    input  logic start_i,
    output logic done_o
);
    import wb_pkg::*;

    logic [MEM_CNT_W-1:0] count;

    // load on start, count down to zero
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count <= '0;
        end else if (start_i) begin
            count <= MEM_CNT_W'(MEM_DELAY);
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    // last cycle of the delay
    assign done_o = (count == MEM_CNT_W'(1));

    a_no_overlap: assert property (@(posedge clk) disable iff (rst)
        start_i |-> count == '0);

endmodule

/* fir/fir_engine.sv */
// FIR engine: taps, sample history, sequential MAC, status and four-phase responder
module fir_engine (
    input  logic              clk,
    input  logic              rst,
    input  logic              req_i,
    input  fir_pkg::fir_cmd_t cmd_i,
    output logic              ack_o,
    output logic [31:0]       rdata_o
);
    import fir_pkg::*;

    logic [31:0]        coef [TAP_NUM];
    // hist[0] is the newest sample
    logic [31:0]        hist [TAP_NUM];
    logic [31:0]        len_q;
    logic [31:0]        cnt_q;
    logic               done_q;
    logic               busy;
    logic               y_valid;
    logic               x_ready;
    logic [TAP_IW-1:0]  mac_idx;
    logic               mac_last;
    logic [31:0]        acc;
    logic [31:0]        y_q;
    logic signed [63:0] prod;
    logic               exec;

    assign x_ready  = !busy && !y_valid;
    assign mac_last = (mac_idx == TAP_IW'(TAP_NUM - 1));
    assign prod     = $signed(coef[mac_idx]) * $signed(hist[mac_idx]);

    // command accepted this cycle, x and y wait for the datapath
    always_comb begin
        exec = req_i && !ack_o;
        if (cmd_i.kind == CMD_X_PUSH) begin
            exec = exec && x_ready;
        end else if (cmd_i.kind == CMD_Y_POP) begin
            exec = exec && y_valid;
        end
    end

    // ------------------------------------------------------------
    // handshake and control state
    // ------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ack_o   <= 1'b0;
            busy    <= 1'b0;
            y_valid <= 1'b0;
            cnt_q   <= '0;
            done_q  <= 1'b0;
            len_q   <= 32'(DATA_NUM);
            hist    <= '{default: '0};
        end else begin
            if (exec) begin
                ack_o <= 1'b1;
            end else if (!req_i) begin
                ack_o <= 1'b0;
            end
            if (busy && mac_last) begin
                busy    <= 1'b0;
                y_valid <= 1'b1;
            end
            if (exec) begin
                case (cmd_i.kind)
                    CMD_CTRL_WR: begin
                        if (cmd_i.data[0]) begin
                            hist   <= '{default: '0};
                            cnt_q  <= '0;
                            done_q <= 1'b0;
                        end
                    end
                    CMD_LEN_WR: len_q <= cmd_i.data;
                    CMD_X_PUSH: begin
                        for (int k = TAP_NUM - 1; k > 0; k--) begin
                            hist[k] <= hist[k-1];
                        end
                        hist[0] <= cmd_i.data;
                        cnt_q   <= cnt_q + 1'b1;
                        busy    <= 1'b1;
                        if (cnt_q + 1'b1 == len_q) begin
                            done_q <= 1'b1;
                        end
                    end
                    CMD_Y_POP: y_valid <= 1'b0;
                    default: ;
                endcase
            end
        end
    end

    // ------------------------------------------------------------
    // taps, MAC datapath and read data
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (exec) begin
            rdata_o <= '0;
            case (cmd_i.kind)
                CMD_STAT_RD: rdata_o <= {29'd0, y_valid, x_ready, done_q};
                CMD_Y_POP:   rdata_o <= y_q;
                CMD_TAP_WR: begin
                    if (cmd_i.tap < TAP_IW'(TAP_NUM)) begin
                        coef[cmd_i.tap] <= cmd_i.data;
                    end
                end
                CMD_X_PUSH: begin
                    mac_idx <= '0;
                    acc     <= '0;
                end
                default: ;
            endcase
        end
        // one tap per cycle, sum wraps at 32 bits
        if (busy) begin
            acc     <= acc + prod[31:0];
            mac_idx <= mac_idx + 1'b1;
            if (mac_last) begin
                y_q <= acc + prod[31:0];
            end
        end
    end

    a_cmd_stable: assert property (@(posedge clk) disable iff (rst)
        (req_i ##1 req_i) |-> $stable(cmd_i));

endmodule

/* exmem/exmem_ram.sv */
// byte-enabled word memory with registered read data
module exmem_ram (
    input  logic                          clk,
    input  logic                          start_i,
    input  wb_pkg::mem_req_t              req_i,
    output logic [wb_pkg::WB_DATA_W-1:0]  rdata_o
);
    import wb_pkg::*;

    logic [WB_DATA_W-1:0] mem [MEM_DEPTH];

    // ------------------------------------------------------------
    // array access
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (start_i) begin
            for (int b = 0; b < WB_SEL_W; b++) begin
                if (req_i.we[b]) begin
                    mem[req_i.addr][8*b +: 8] <= req_i.wdata[8*b +: 8];
                end
            end
        end
    end

    // old word on a write, held until the next access
    always_ff @(posedge clk) begin
        if (start_i) begin
            rdata_o <= mem[req_i.addr];
        end
    end

endmodule

/* common/fir_pkg.sv */
// filter constants, register offsets, command kinds and command struct
package fir_pkg;

    // ------------------------------------------------------------
    // filter sizes
    // ------------------------------------------------------------
    localparam int TAP_NUM  = 11;
    // stream length after reset
    localparam int DATA_NUM = 64;
    localparam int TAP_IW   = 4;

    // offset bits inside the filter window
    localparam int REG_OFF_W = 12;

    // ------------------------------------------------------------
    // register offsets
    // ------------------------------------------------------------
    localparam logic [REG_OFF_W-1:0] REG_CTRL = 12'h000;
    localparam logic [REG_OFF_W-1:0] REG_LEN  = 12'h010;
    localparam logic [REG_OFF_W-1:0] REG_X    = 12'h040;
    localparam logic [REG_OFF_W-1:0] REG_Y    = 12'h044;
    // taps follow at word steps
    localparam logic [REG_OFF_W-1:0] REG_TAP0 = 12'h080;

    // ------------------------------------------------------------
    // command channel
    // ------------------------------------------------------------
    typedef enum logic [2:0] {
        CMD_CTRL_WR = 3'd0,
        CMD_STAT_RD = 3'd1,
        CMD_LEN_WR  = 3'd2,
        CMD_TAP_WR  = 3'd3,
        CMD_X_PUSH  = 3'd4,
        CMD_Y_POP   = 3'd5
    } fir_kind_e;

    typedef struct packed {
        fir_kind_e         kind;
        logic [TAP_IW-1:0] tap;
        logic [31:0]       data;
    } fir_cmd_t;

endpackage

/* common/wb_pkg.sv */
// bus widths, address map, memory constants and request structs
package wb_pkg;

    // ------------------------------------------------------------
    // bus widths
    // ------------------------------------------------------------
    localparam int WB_ADDR_W = 32;
    localparam int WB_DATA_W = 32;
    localparam int WB_SEL_W  = 4;

    // ------------------------------------------------------------
    // address map
    // ------------------------------------------------------------
    localparam logic [WB_ADDR_W-1:0] FIR_BASE = 32'h3000_0000;
    localparam logic [WB_ADDR_W-1:0] MEM_BASE = 32'h3800_0000;

    // memory window
    localparam int MEM_DEPTH = 1024;
    localparam int MEM_AW    = 10;
    // fixed latency of every memory access
    localparam int MEM_DELAY = 10;
    localparam int MEM_CNT_W = $clog2(MEM_DELAY + 1);

    // ------------------------------------------------------------
    // structs
    // ------------------------------------------------------------
    // request as sampled off the bus
    typedef struct packed {
        logic                 we;
        logic [WB_SEL_W-1:0]  sel;
        logic [WB_ADDR_W-1:0] adr;
        logic [WB_DATA_W-1:0] dat;
    } wb_req_t;

    // word access to the memory array, we already masked by sel
    typedef struct packed {
        logic [WB_SEL_W-1:0]  we;
        logic [MEM_AW-1:0]    addr;
        logic [WB_DATA_W-1:0] wdata;
    } mem_req_t;

endpackage
